/* vlog.f */
common/boardman_pkg.sv
hw/cmd_rx/cmd_rx.sv
hw/bus_engine/bus_engine.sv
hw/rsp_tx/rsp_tx.sv
hw/boardman_top.sv
verif/tb_clkgen.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_top -o tb_sim
out=$(./obj_dir/tb_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

/* verif/tb_top.sv */
module tb_top;
    import boardman_pkg::*;

    localparam int N_TESTS   = 5;
    localparam int MEM_WORDS = 256;
    localparam int RSP_WAIT  = 300;
    localparam int SEED      = 3936;

    // one observed or expected bus write
    typedef struct packed {
        logic [19:0] adr;
        logic [3:0]  strb;
        logic [31:0] data;
    } wr_rec_t;

    logic        clk;
    logic        arst_n;
    axis_beat_t  rx_beat_i;
    logic        rx_tvalid_i;
    logic        rx_tready_o;
    logic [7:0]  tx_tdata_o;
    logic        tx_tlast_o;
    logic        tx_tvalid_o;
    logic        tx_tready_i;
    bus_req_t    bus_o;
    logic [31:0] bus_rdata_i;
    logic        bus_ack_i;

    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] model_mem [0:MEM_WORDS-1];
    integer      seed;
    logic        bp_on;
    logic        bus_range_err;
    int          rd_count;
    int          rd_seen;
    int          err_value;
    int          err_other;

    logic [7:0]  pkt_q[$];
    logic [8:0]  exp_rsp[$];
    logic [8:0]  tx_q[$];
    int          tx_rd;
    wr_rec_t     exp_wr[$];
    wr_rec_t     wr_log[$];
    int          wr_rd;

    tb_clkgen #(.PERIOD(4), .RST_CYCLES(4)) clkgen_i (.clk_o(clk), .arst_n_o(arst_n));

    boardman_top dut_i (
        .clk, .arst_n_i(arst_n),
        .rx_beat_i, .rx_tvalid_i, .rx_tready_o,
        .tx_tdata_o, .tx_tlast_o, .tx_tvalid_o, .tx_tready_i,
        .bus_o, .bus_rdata_i, .bus_ack_i
    );

    // memory contents before any write, mixing every address bit
    function automatic logic [31:0] fill_word(input logic [19:0] a);
        return {a[7:0] ^ 8'hc3, a[15:8] + a[7:0] + 8'h5a, ~a[7:0], a[7:0] ^ {4'h0, a[19:16]}};
    endfunction

    task automatic compare_hex(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            err_value++;
            $display("ERR %s got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic require_true(input logic cond, input string what);
        assert (cond) else begin
            err_other++;
            $display("%s", what);
        end
    endtask

    // tx bytes as {last, data}, never cleared
    // sampled midway between the falling and the rising edge
    initial begin : tx_monitor
        forever begin
            @(negedge clk);
            #1;
            if (tx_tvalid_o && tx_tready_i) begin
                tx_q.push_back({tx_tlast_o, tx_tdata_o});
            end
        end
    end

    // memory model with random wait states, also drives tx back-pressure
    initial begin : bus_responder
        int         wait_left;
        int         i;
        int         b;
        logic [7:0] idx;
        wr_rec_t    rec;
        seed          = SEED;
        bus_ack_i     = 1'b0;
        bus_rdata_i   = '0;
        tx_tready_i   = 1'b0;
        bus_range_err = 1'b0;
        rd_count      = 0;
        wait_left     = -1;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(20'(i));
        end
        forever begin
            @(negedge clk);
            if (bp_on) begin
                tx_tready_i = ($random(seed) & 1) != 0;
            end else begin
                tx_tready_i = 1'b1;
            end
            if (bus_ack_i) begin
                bus_ack_i = 1'b0;
            end else if (bus_o.en) begin
                if (wait_left < 0) begin
                    wait_left = $random(seed) & 3;
                end
                if (wait_left == 0) begin
                    idx = bus_o.adr[7:0];
                    if (bus_o.adr[19:8] != 12'h0) begin
                        bus_range_err = 1'b1;
                    end
                    if (bus_o.wr) begin
                        for (b = 0; b < 4; b++) begin
                            if (bus_o.wstrb[b]) begin
                                mem[idx][b*8 +: 8] = bus_o.wdata[b*8 +: 8];
                            end
                        end
                        rec.adr  = bus_o.adr;
                        rec.strb = bus_o.wstrb;
                        rec.data = bus_o.wdata;
                        wr_log.push_back(rec);
                    end else begin
                        bus_rdata_i = mem[idx];
                        rd_count++;
                    end
                    bus_ack_i = 1'b1;
                    wait_left = -1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // holds the beat until rx_tready_o is high ahead of a rising edge
    task automatic drive_beat(input logic [7:0] d, input logic l, input logic u);
        logic taken;
        rx_beat_i.data = d;
        rx_beat_i.last = l;
        rx_beat_i.user = u;
        rx_tvalid_i    = 1'b1;
        taken          = 1'b0;
        while (!taken) begin
            #1;
            taken = rx_tready_o;
            @(negedge clk);
        end
    endtask

    task automatic send_packet(input logic end_with_user);
        int i;
        for (i = 0; i < pkt_q.size(); i++) begin
            drive_beat(pkt_q[i], (i == pkt_q.size() - 1) && !end_with_user, 1'b0);
        end
        if (end_with_user) begin
            drive_beat(8'hee, 1'b1, 1'b1);
        end
        rx_tvalid_i = 1'b0;
        rx_beat_i   = '0;
    endtask

    task automatic start_packet(input logic [23:0] h);
        pkt_q.delete();
        pkt_q.push_back(h[23:16]);
        pkt_q.push_back(h[15:8]);
        pkt_q.push_back(h[7:0]);
    endtask

    task automatic expect_header(input logic [23:0] h);
        exp_rsp.delete();
        exp_rsp.push_back({1'b0, h[23:16]});
        exp_rsp.push_back({1'b0, h[15:8]});
        exp_rsp.push_back({1'b0, h[7:0]});
    endtask

    // lanes fill little-endian, a word goes out on lane 3 or on the final byte
    task automatic model_write(input logic [23:0] h, input int n, input logic aborted);
        logic [1:0]  lane;
        logic [19:0] wadr;
        wr_rec_t     rec;
        int          i;
        int          b;
        lane     = h[1:0];
        wadr     = h[21:2];
        rec      = '0;
        rec.adr  = wadr;
        for (i = 0; i < n; i++) begin
            rec.data[lane*8 +: 8] = pkt_q[HDR_BYTES + i];
            rec.strb[lane]        = 1'b1;
            if (lane == 2'd3 || (i == n - 1 && !aborted)) begin
                exp_wr.push_back(rec);
                for (b = 0; b < 4; b++) begin
                    if (rec.strb[b]) begin
                        model_mem[wadr[7:0]][b*8 +: 8] = rec.data[b*8 +: 8];
                    end
                end
                if (!h[22]) begin
                    wadr = wadr + 20'd1;
                end
                lane    = 2'd0;
                rec     = '0;
                rec.adr = wadr;
            end else begin
                lane = lane + 2'd1;
            end
        end
    endtask

    task automatic model_read(input logic [23:0] h, input logic [7:0] len);
        logic [1:0]  lane;
        logic [19:0] wadr;
        int          i;
        lane = h[1:0];
        wadr = h[21:2];
        for (i = 0; i <= int'(len); i++) begin
            exp_rsp.push_back({i == int'(len), model_mem[wadr[7:0]][lane*8 +: 8]});
            if (lane == 2'd3) begin
                lane = 2'd0;
                if (!h[22]) begin
                    wadr = wadr + 20'd1;
                end
            end else begin
                lane = lane + 2'd1;
            end
        end
    endtask

    task automatic check_response();
        int   n;
        int   i;
        logic seen;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < RSP_WAIT) begin
            @(negedge clk);
            n++;
            if (tx_q.size() > tx_rd) begin
                seen = tx_q[tx_q.size() - 1][8];
            end
        end
        require_true(seen, "response ending with tlast did not arrive in time");
        compare_hex("response length", 32'(tx_q.size() - tx_rd), 32'(exp_rsp.size()));
        for (i = 0; i < exp_rsp.size() && tx_rd + i < tx_q.size(); i++) begin
            compare_hex("tx_tdata_o", 32'(tx_q[tx_rd + i][7:0]), 32'(exp_rsp[i][7:0]));
            compare_hex("tx_tlast_o", 32'(tx_q[tx_rd + i][8]), 32'(exp_rsp[i][8]));
        end
        tx_rd = tx_q.size();
    endtask

    task automatic expect_silence(input int cycles);
        repeat (cycles) @(negedge clk);
        require_true(tx_q.size() == tx_rd, "a dropped packet produced response bytes");
        tx_rd = tx_q.size();
    endtask

    task automatic check_bus_traffic(input int n_reads);
        int i;
        int b;
        compare_hex("bus write count", 32'(wr_log.size() - wr_rd), 32'(exp_wr.size()));
        for (i = 0; i < exp_wr.size() && wr_rd + i < wr_log.size(); i++) begin
            compare_hex("bus_o.adr", 32'(wr_log[wr_rd + i].adr), 32'(exp_wr[i].adr));
            compare_hex("bus_o.wstrb", 32'(wr_log[wr_rd + i].strb), 32'(exp_wr[i].strb));
            for (b = 0; b < 4; b++) begin
                if (exp_wr[i].strb[b]) begin
                    compare_hex("bus_o.wdata", 32'(wr_log[wr_rd + i].data[b*8 +: 8]),
                                32'(exp_wr[i].data[b*8 +: 8]));
                end
            end
        end
        wr_rd = wr_log.size();
        exp_wr.delete();
        compare_hex("bus read count", 32'(rd_count - rd_seen), 32'(n_reads));
        rd_seen = rd_count;
    endtask

    task automatic check_memory();
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            compare_hex($sformatf("mem[%0h]", i), mem[i], model_mem[i]);
        end
    endtask

    task automatic write_single_word();
        logic [23:0] h;
        h = {1'b1, 1'b0, 22'h000040};
        start_packet(h);
        pkt_q.push_back(8'h11);
        pkt_q.push_back(8'h22);
        pkt_q.push_back(8'h33);
        pkt_q.push_back(8'h44);
        expect_header(h);
        exp_rsp.push_back({1'b1, 8'd4});
        model_write(h, 4, 1'b0);
        send_packet(1'b0);
        check_response();
        check_bus_traffic(0);
        check_memory();
    endtask

    task automatic write_incr_lane2();
        logic [23:0] h;
        int          i;
        h = {1'b1, 1'b0, 22'h000082};
        start_packet(h);
        for (i = 0; i < 6; i++) begin
            pkt_q.push_back(8'ha0 + 8'(i));
        end
        expect_header(h);
        exp_rsp.push_back({1'b1, 8'd6});
        model_write(h, 6, 1'b0);
        send_packet(1'b0);
        check_response();
        check_bus_traffic(0);
        check_memory();
    endtask

    task automatic read_backpressure();
        logic [23:0] h;
        h = {1'b0, 1'b0, 22'h0000c1};
        start_packet(h);
        pkt_q.push_back(8'd5);
        expect_header(h);
        model_read(h, 8'd5);
        bp_on = 1'b1;
        send_packet(1'b0);
        check_response();
        bp_on = 1'b0;
        check_bus_traffic(2);
    endtask

    task automatic read_hold();
        logic [23:0] h;
        h = {1'b0, 1'b1, 22'h000040};
        start_packet(h);
        pkt_q.push_back(8'd7);
        expect_header(h);
        model_read(h, 8'd7);
        send_packet(1'b0);
        check_response();
        check_bus_traffic(2);
    endtask

    task automatic framing_errors();
        logic [23:0] h;
        int          i;
        // header cut short by tlast on its second byte
        pkt_q.delete();
        pkt_q.push_back(8'h80);
        pkt_q.push_back(8'h01);
        send_packet(1'b0);
        expect_silence(40);
        check_bus_traffic(0);
        // write poisoned after five data bytes
        h = {1'b1, 1'b0, 22'h0000a0};
        start_packet(h);
        for (i = 0; i < 5; i++) begin
            pkt_q.push_back(8'h50 + 8'(i));
        end
        model_write(h, 5, 1'b1);
        send_packet(1'b1);
        expect_silence(40);
        check_bus_traffic(0);
        check_memory();
        // a clean read across both words afterwards
        h = {1'b0, 1'b0, 22'h0000a0};
        start_packet(h);
        pkt_q.push_back(8'd7);
        expect_header(h);
        model_read(h, 8'd7);
        send_packet(1'b0);
        check_response();
        check_bus_traffic(2);
    endtask

    initial begin : watchdog
        repeat (N_TESTS * 400) @(posedge clk);
        $display("watchdog expired after %0d cycles before the tests finished", N_TESTS * 400);
        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
        $display("sim failed");
        $finish;
    end

    initial begin : main
        int i;
        rx_beat_i   = '0;
        rx_tvalid_i = 1'b0;
        bp_on       = 1'b0;
        err_value   = 0;
        err_other   = 0;
        tx_rd       = 0;
        wr_rd       = 0;
        rd_seen     = 0;
        for (i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = fill_word(20'(i));
        end
        wait (arst_n === 1'b1);
        repeat (2) @(negedge clk);
        require_true(!tx_tvalid_o && !bus_o.en, "tx valid or bus enable high after reset");
        write_single_word();
        write_incr_lane2();
        read_backpressure();
        read_hold();
        framing_errors();
        require_true(!bus_range_err, "bus access outside the modeled memory");
        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verif/tb_clkgen.sv */
module tb_clkgen #(
    parameter int PERIOD     = 4,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

    // release falls on a falling edge, away from the sampling edge
    initial begin
        arst_n_o = 1'b0;
        #(PERIOD * RST_CYCLES) arst_n_o = 1'b1;
    end

endmodule

/* hw/boardman_top.sv */
module boardman_top (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  boardman_pkg::axis_beat_t         rx_beat_i,
    input  logic                             rx_tvalid_i,
    output logic                             rx_tready_o,
    output logic [7:0]                       tx_tdata_o,
    output logic                             tx_tlast_o,
    output logic                             tx_tvalid_o,
    input  logic                             tx_tready_i,
    output boardman_pkg::bus_req_t           bus_o,
    input  logic [boardman_pkg::DATA_W-1:0]  bus_rdata_i,
    input  logic                             bus_ack_i
);
    import boardman_pkg::*;

    // command path
    bm_cmd_t  cmd;
    logic     cmd_valid;
    logic     cmd_ready;

    // write data path
    wbeat_t   wbeat;
    logic     wbeat_valid;
    logic     wbeat_ready;
    logic     abort;

    // response path
    rsp_job_t job;
    logic     job_valid;
    logic     job_ready;
    rbeat_t   rbeat;
    logic     rbeat_valid;
    logic     rbeat_ready;

    cmd_rx cmd_rx_i (
        .clk, .arst_n_i,
        .rx_beat_i, .rx_tvalid_i, .rx_tready_o,
        .cmd_o(cmd), .cmd_valid_o(cmd_valid), .cmd_ready_i(cmd_ready),
        .wbeat_o(wbeat), .wbeat_valid_o(wbeat_valid), .wbeat_ready_i(wbeat_ready),
        .abort_o(abort)
    );

    bus_engine bus_engine_i (
        .clk, .arst_n_i,
        .cmd_i(cmd), .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready),
        .wbeat_i(wbeat), .wbeat_valid_i(wbeat_valid), .wbeat_ready_o(wbeat_ready),
        .abort_i(abort),
        .bus_o, .bus_rdata_i, .bus_ack_i,
        .job_o(job), .job_valid_o(job_valid), .job_ready_i(job_ready),
        .rbeat_o(rbeat), .rbeat_valid_o(rbeat_valid), .rbeat_ready_i(rbeat_ready)
    );

    rsp_tx rsp_tx_i (
        .clk, .arst_n_i,
        .job_i(job), .job_valid_i(job_valid), .job_ready_o(job_ready),
        .rbeat_i(rbeat), .rbeat_valid_i(rbeat_valid), .rbeat_ready_o(rbeat_ready),
        .tx_tdata_o, .tx_tlast_o, .tx_tvalid_o, .tx_tready_i
    );

endmodule

/* hw/rsp_tx/rsp_tx.sv */
module rsp_tx (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  boardman_pkg::rsp_job_t job_i,
    input  logic                   job_valid_i,
    output logic                   job_ready_o,
    input  boardman_pkg::rbeat_t   rbeat_i,
    input  logic                   rbeat_valid_i,
    output logic                   rbeat_ready_o,
    output logic [7:0]             tx_tdata_o,
    output logic                   tx_tlast_o,
    output logic                   tx_tvalid_o,
    input  logic                   tx_tready_i
);
    import boardman_pkg::*;

    typedef enum logic [1:0] {
        T_IDLE, T_HDR, T_CNT, T_RD
    } state_t;

    state_t     state;
    rsp_job_t   job_q;
    logic [1:0] idx;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= T_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                T_IDLE: if (job_valid_i) begin
                    idx   <= 2'(HDR_BYTES - 1);
                    state <= T_HDR;
                end
                T_HDR: if (tx_tready_i) begin
                    if (idx == 2'd0) begin
                        state <= job_q.hdr.fields.is_write ? T_CNT : T_RD;
                    end else begin
                        idx <= idx - 2'd1;
                    end
                end
                T_CNT: if (tx_tready_i) begin
                    state <= T_IDLE;
                end
                T_RD: if (rbeat_valid_i && tx_tready_i && rbeat_i.last) begin
                    state <= T_IDLE;
                end
                default: state <= T_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (job_valid_i && job_ready_o) begin
            job_q <= job_i;
        end
    end

    assign job_ready_o   = (state == T_IDLE);
    // read bytes pass straight through after the echo
    assign rbeat_ready_o = (state == T_RD) && tx_tready_i;

    always_comb begin
        case (state)
            T_HDR: begin
                tx_tdata_o  = job_q.hdr.bytes[idx];
                tx_tlast_o  = 1'b0;
                tx_tvalid_o = 1'b1;
            end
            T_CNT: begin
                tx_tdata_o  = job_q.count;
                tx_tlast_o  = 1'b1;
                tx_tvalid_o = 1'b1;
            end
            T_RD: begin
                tx_tdata_o  = rbeat_i.data;
                tx_tlast_o  = rbeat_i.last;
                tx_tvalid_o = rbeat_valid_i;
            end
            default: begin
                tx_tdata_o  = 8'h00;
                tx_tlast_o  = 1'b0;
                tx_tvalid_o = 1'b0;
            end
        endcase
    end

    // holds across the engine too, since read bytes come from there
    a_tx_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        (tx_tvalid_o && !tx_tready_i) |=>
            (tx_tvalid_o && $stable(tx_tdata_o) && $stable(tx_tlast_o)));

endmodule

/* hw/bus_engine/bus_engine.sv */
module bus_engine (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  boardman_pkg::bm_cmd_t            cmd_i,
    input  logic                             cmd_valid_i,
    output logic                             cmd_ready_o,
    input  boardman_pkg::wbeat_t             wbeat_i,
    input  logic                             wbeat_valid_i,
    output logic                             wbeat_ready_o,
    input  logic                             abort_i,
    output boardman_pkg::bus_req_t           bus_o,
    input  logic [boardman_pkg::DATA_W-1:0]  bus_rdata_i,
    input  logic                             bus_ack_i,
    output boardman_pkg::rsp_job_t           job_o,
    output logic                             job_valid_o,
    input  logic                             job_ready_i,
    output boardman_pkg::rbeat_t             rbeat_o,
    output logic                             rbeat_valid_o,
    input  logic                             rbeat_ready_i
);
    import boardman_pkg::*;

    typedef enum logic [2:0] {
        E_IDLE, E_WFILL, E_WBUS, E_WJOB, E_RBUS, E_RSEND
    } state_t;

    state_t                 state;
    bm_hdr_u                hdr;
    logic [WORD_ADDR_W-1:0] wadr;
    logic [LANE_W-1:0]      lane;
    logic [DATA_W-1:0]      data;
    logic [LANES-1:0]       strb;
    logic [7:0]             cnt;
    logic                   req_en;
    logic                   req_wr;
    logic                   last_word;
    logic                   aborted;
    logic                   job_valid;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state     <= E_IDLE;
            wadr      <= '0;
            lane      <= '0;
            strb      <= '0;
            cnt       <= '0;
            req_en    <= 1'b0;
            req_wr    <= 1'b0;
            last_word <= 1'b0;
            aborted   <= 1'b0;
            job_valid <= 1'b0;
        end else begin
            if (job_valid && job_ready_i) begin
                job_valid <= 1'b0;
            end
            case (state)
                E_IDLE: if (cmd_valid_i && cmd_ready_o) begin
                    wadr    <= cmd_i.hdr.fields.addr[ADDR_W-1:LANE_W];
                    lane    <= cmd_i.hdr.fields.addr[LANE_W-1:0];
                    strb    <= '0;
                    aborted <= 1'b0;
                    if (cmd_i.hdr.fields.is_write) begin
                        cnt   <= '0;
                        state <= E_WFILL;
                    end else begin
                        // read job goes out together with the first access
                        cnt       <= cmd_i.len;
                        req_en    <= 1'b1;
                        job_valid <= 1'b1;
                        state     <= E_RBUS;
                    end
                end
                E_WFILL: if (abort_i) begin
                    // partial word is simply dropped
                    state <= E_IDLE;
                end else if (wbeat_valid_i) begin
                    strb[lane] <= 1'b1;
                    cnt        <= cnt + 8'd1;
                    lane       <= lane + 2'd1;
                    if (&lane || wbeat_i.last) begin
                        req_en    <= 1'b1;
                        req_wr    <= 1'b1;
                        last_word <= wbeat_i.last;
                        lane      <= '0;
                        state     <= E_WBUS;
                    end
                end
                E_WBUS: begin
                    if (abort_i) begin
                        aborted <= 1'b1;
                    end
                    if (bus_ack_i) begin
                        req_en <= 1'b0;
                        req_wr <= 1'b0;
                        strb   <= '0;
                        if (!hdr.fields.hold) begin
                            wadr <= wadr + 20'd1;
                        end
                        if (aborted || abort_i) begin
                            state <= E_IDLE;
                        end else if (last_word) begin
                            job_valid <= 1'b1;
                            state     <= E_WJOB;
                        end else begin
                            state <= E_WFILL;
                        end
                    end
                end
                E_WJOB: if (job_ready_i) begin
                    state <= E_IDLE;
                end
                E_RBUS: if (bus_ack_i) begin
                    req_en <= 1'b0;
                    state  <= E_RSEND;
                end
                E_RSEND: if (rbeat_ready_i) begin
                    if (cnt == 8'd0) begin
                        state <= E_IDLE;
                    end else begin
                        cnt  <= cnt - 8'd1;
                        lane <= lane + 2'd1;
                        // lane wraps so fetch the next word
                        if (&lane) begin
                            if (!hdr.fields.hold) begin
                                wadr <= wadr + 20'd1;
                            end
                            req_en <= 1'b1;
                            state  <= E_RBUS;
                        end
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == E_IDLE && cmd_valid_i && cmd_ready_o) begin
            hdr <= cmd_i.hdr;
        end
        if (state == E_WFILL && wbeat_valid_i) begin
            data[lane*8 +: 8] <= wbeat_i.data;
        end else if (state == E_RBUS && bus_ack_i) begin
            data <= bus_rdata_i;
        end
    end

    assign cmd_ready_o   = (state == E_IDLE) && !job_valid;
    assign wbeat_ready_o = (state == E_WFILL);

    assign bus_o.en    = req_en;
    assign bus_o.wr    = req_wr;
    assign bus_o.adr   = wadr;
    assign bus_o.wdata = data;
    assign bus_o.wstrb = strb;

    assign job_o.hdr   = hdr;
    assign job_o.count = cnt;
    assign job_valid_o = job_valid;

    assign rbeat_o.data  = data[lane*8 +: 8];
    assign rbeat_o.last  = (cnt == 8'd0);
    assign rbeat_valid_o = (state == E_RSEND);

    a_bus_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        (bus_o.en && !bus_ack_i) |=> $stable(bus_o));

endmodule

/* hw/cmd_rx/cmd_rx.sv */
module cmd_rx (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  boardman_pkg::axis_beat_t rx_beat_i,
    input  logic                     rx_tvalid_i,
    output logic                     rx_tready_o,
    output boardman_pkg::bm_cmd_t    cmd_o,
    output logic                     cmd_valid_o,
    input  logic                     cmd_ready_i,
    output boardman_pkg::wbeat_t     wbeat_o,
    output logic                     wbeat_valid_o,
    input  logic                     wbeat_ready_i,
    output logic                     abort_o
);
    import boardman_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_HDR, S_RLEN, S_CMD, S_WDATA, S_DUMP
    } state_t;

    state_t     state;
    logic [1:0] hdr_idx;
    bm_hdr_u    hdr;
    logic [7:0] len;
    logic       bad;

    // a beat that ends or poisons the packet
    assign bad = rx_beat_i.last || rx_beat_i.user;

    always_comb begin
        case (state)
            S_IDLE, S_HDR, S_RLEN, S_DUMP: rx_tready_o = 1'b1;
            // user beats are always swallowed, data waits for the engine
            S_WDATA: rx_tready_o = rx_beat_i.user || wbeat_ready_i;
            default: rx_tready_o = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state   <= S_IDLE;
            hdr_idx <= '0;
        end else begin
            case (state)
                S_IDLE: if (rx_tvalid_i && !bad) begin
                    hdr_idx <= 2'(HDR_BYTES - 2);
                    state   <= S_HDR;
                end
                S_HDR: if (rx_tvalid_i) begin
                    if (bad) begin
                        state <= rx_beat_i.last ? S_IDLE : S_DUMP;
                    end else if (hdr_idx == 2'd0) begin
                        // top header byte is already stored, so is_write is known
                        state <= hdr.fields.is_write ? S_CMD : S_RLEN;
                    end else begin
                        hdr_idx <= hdr_idx - 2'd1;
                    end
                end
                S_RLEN: if (rx_tvalid_i) begin
                    if (rx_beat_i.user || !rx_beat_i.last) begin
                        state <= rx_beat_i.last ? S_IDLE : S_DUMP;
                    end else begin
                        state <= S_CMD;
                    end
                end
                S_CMD: if (cmd_ready_i) begin
                    state <= hdr.fields.is_write ? S_WDATA : S_IDLE;
                end
                S_WDATA: if (rx_tvalid_i && rx_tready_o) begin
                    if (rx_beat_i.user) begin
                        state <= rx_beat_i.last ? S_IDLE : S_DUMP;
                    end else if (rx_beat_i.last) begin
                        state <= S_IDLE;
                    end
                end
                S_DUMP: if (rx_tvalid_i && bad) begin
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // header and length capture
    always_ff @(posedge clk) begin
        if (state == S_IDLE && rx_tvalid_i && !bad) begin
            hdr.bytes[HDR_BYTES-1] <= rx_beat_i.data;
        end else if (state == S_HDR && rx_tvalid_i && !bad) begin
            hdr.bytes[hdr_idx] <= rx_beat_i.data;
        end
        if (state == S_RLEN && rx_tvalid_i) begin
            len <= rx_beat_i.data;
        end
    end

    assign cmd_o.hdr   = hdr;
    assign cmd_o.len   = len;
    assign cmd_valid_o = (state == S_CMD);

    assign wbeat_o.data  = rx_beat_i.data;
    assign wbeat_o.last  = rx_beat_i.last;
    assign wbeat_valid_o = (state == S_WDATA) && rx_tvalid_i && !rx_beat_i.user;
    assign abort_o       = (state == S_WDATA) && rx_tvalid_i && rx_beat_i.user;

    // no new command while more write data is still expected
    a_no_cmd_in_wdata: assert property (@(posedge clk) disable iff (!arst_n_i)
        (wbeat_valid_o && !wbeat_o.last) |=> !cmd_valid_o);

endmodule

/* common/boardman_pkg.sv */
package boardman_pkg;

    // wire protocol geometry
    localparam int HDR_BYTES   = 3;
    localparam int ADDR_W      = 22;
    localparam int LANE_W      = 2;
    localparam int LANES       = 4;
    localparam int WORD_ADDR_W = ADDR_W - LANE_W;
    localparam int DATA_W      = 32;

    // decoded view of the 24-bit command header
    typedef struct packed {
        logic              is_write;
        logic              hold;
        logic [ADDR_W-1:0] addr;
    } bm_hdr_fields_t;

    // bytes[2] is the first byte on the wire
    typedef union packed {
        logic [HDR_BYTES-1:0][7:0] bytes;
        bm_hdr_fields_t            fields;
    } bm_hdr_u;

    // one incoming stream beat
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } axis_beat_t;

    // accepted command, len only meaningful for reads
    typedef struct packed {
        bm_hdr_u    hdr;
        logic [7:0] len;
    } bm_cmd_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } wbeat_t;

    // register bus request
    typedef struct packed {
        logic                   en;
        logic                   wr;
        logic [WORD_ADDR_W-1:0] adr;
        logic [DATA_W-1:0]      wdata;
        logic [LANES-1:0]       wstrb;
    } bus_req_t;

    // response job, count only sent for writes
    typedef struct packed {
        bm_hdr_u    hdr;
        logic [7:0] count;
    } rsp_job_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } rbeat_t;

endpackage
